/* common/mergePkg.sv */
/*
  Shared sizes and vector types for the priority merge unit
  FifoDepth must be a power of two because buffer pointers wrap by overflow
  LaneIdxWidth must be wide enough to tag every one of NumLanes lanes
*/
package mergePkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------

  // Lanes and lane buffers, lane 0 has the highest priority
  localparam int NumLanes = 4;

  // Payload word
  localparam int DataWidth = 16;

  // Lane tag carried with each input word
  localparam int LaneIdxWidth = 2;

  // Entries per lane buffer
  localparam int FifoDepth = 4;

  // Read and write pointer width inside a lane buffer
  localparam int FifoPtrWidth = $clog2(FifoDepth);

  // ------------------------------------------------------------
  // Vector types
  // ------------------------------------------------------------

  // One payload word
  typedef logic [DataWidth-1:0] dataT;

  // Lane tag on input, lane index on output
  typedef logic [LaneIdxWidth-1:0] laneIdxT;

  // One bit per lane
  // Used for valid, ready, request and grant vectors
  typedef logic [NumLanes-1:0] laneVecT;

endpackage : mergePkg

/* source/laneSteer.sv */
/*
  Routes one tagged input handshake to one of the lane buffers
  Purely combinational, no state
  inReady follows the tagged lane only and does not wait for inValid
*/
`timescale 1ns/1ps

module laneSteer (
  input  logic              inValid,
  output logic              inReady,
  input  mergePkg::laneIdxT inLane,
  output mergePkg::laneVecT pushValid,
  input  mergePkg::laneVecT fifoReady
);

  import mergePkg::*;

  // ------------------------------------------------------------
  // Push decode
  // ------------------------------------------------------------

  // One-hot valid toward the buffers
  // At most one bit is set, and only while inValid is high
  always_comb begin
    pushValid = '0;
    for (int i = 0; i < NumLanes; i++) begin
      // Compare the tag against each lane index
      if (inLane == laneIdxT'(i)) begin
        pushValid[i] = inValid;
      end
    end
  end

  // ------------------------------------------------------------
  // Ready return
  // ------------------------------------------------------------

  // Producer sees only the tagged lane's ready
  // Other lanes being full does not stall this word
  assign inReady = fifoReady[inLane];

  // Handshake on the input side therefore equals
  // pushValid[inLane] && fifoReady[inLane]
  // so no word is ever written into more than one buffer

endmodule : laneSteer

/* source/laneFifo.sv */
/*
  Circular buffer for one lane, ready-valid on push and pop sides
  One cycle from push to pop valid, no bypass path
  pushReady is the not-full flag so a full buffer refuses a push even while popping
  Storage has no reset, only pointers and occupancy are cleared
*/
`timescale 1ns/1ps

module laneFifo (
  input  logic           clk,
  input  logic           rstN,
  input  logic           pushValid,
  output logic           pushReady,
  input  mergePkg::dataT pushData,
  output logic           popValid,
  input  logic           popReady,
  output mergePkg::dataT popData
);

  import mergePkg::*;

  // ------------------------------------------------------------
  // State
  // ------------------------------------------------------------

  // Word storage
  dataT mem [FifoDepth];

  // Pointers wrap by overflow, depth is a power of two
  logic [FifoPtrWidth-1:0] wrPtr;
  logic [FifoPtrWidth-1:0] rdPtr;

  // Occupancy, one extra bit to tell full from empty
  logic [FifoPtrWidth:0] count;

  // Completed handshakes this cycle
  logic doPush;
  logic doPop;

  // ------------------------------------------------------------
  // Flags and handshakes
  // ------------------------------------------------------------

  assign pushReady = (count != (FifoPtrWidth + 1)'(FifoDepth));
  assign popValid  = (count != '0);

  assign doPush = pushValid && pushReady;
  assign doPop  = popValid && popReady;

  // Head entry, held until it is popped
  assign popData = mem[rdPtr];

  // ------------------------------------------------------------
  // Storage write
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

  // ------------------------------------------------------------
  // Pointer and occupancy update
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      // Simultaneous push and pop leaves the count unchanged
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule : laneFifo

/* flowMux/fixedPrioArb.sv */
/*
  Fixed-priority arbiter, lowest requesting index wins
  Combinational, no priority state and no fairness
  grant is canGrant qualified by enable
*/
`timescale 1ns/1ps

module fixedPrioArb (
  input  mergePkg::laneVecT request,
  output mergePkg::laneVecT canGrant,
  output mergePkg::laneVecT grant,
  input  logic              enable
);

  import mergePkg::*;

  // Set at a bit when any lower index is requesting
  laneVecT blocked;

  // ------------------------------------------------------------
  // Priority chain
  // ------------------------------------------------------------

  always_comb begin
    blocked[0] = 1'b0;
    // Ripple from lane 0 upward
    for (int i = 1; i < NumLanes; i++) begin
      blocked[i] = blocked[i-1] | request[i-1];
    end
  end

  // Lowest set request bit only
  assign canGrant = request & ~blocked;

  // Winner only takes the grant when the pop side is ready
  assign grant = canGrant & {NumLanes{enable}};

endmodule : fixedPrioArb

/* flowMux/flowMuxFixed.sv */
/*
  Fixed-priority flow multiplexer, lowest lane index wins
  Purely combinational from push side to pop side
  popData and popLane may change while popReady is low if a higher lane fills
  popLane is meaningful only while popValid is high
*/
`timescale 1ns/1ps

module flowMuxFixed (
  input  mergePkg::laneVecT                       pushValid,
  output mergePkg::laneVecT                       pushReady,
  input  mergePkg::dataT [mergePkg::NumLanes-1:0] pushData,
  output logic                                    popValid,
  input  logic                                    popReady,
  output mergePkg::dataT                          popData,
  output mergePkg::laneIdxT                       popLane
);

  import mergePkg::*;

  // Winner before and after pop-side qualification
  laneVecT canGrant;
  laneVecT grant;

  // ------------------------------------------------------------
  // Arbitration
  // ------------------------------------------------------------

  // Every valid lane requests
  fixedPrioArb uFixedPrioArb (
    .request  (pushValid),
    .canGrant (canGrant),
    .grant    (grant),
    .enable   (popReady)
  );

  // Only the granted lane pops, and only with popReady high
  assign pushReady = grant;

  // Something is offered whenever any lane is valid
  assign popValid = |pushValid;

  // ------------------------------------------------------------
  // Data select and lane encode
  // ------------------------------------------------------------

  // canGrant is one-hot or zero, so at most one branch hits
  always_comb begin
    popData = '0;
    popLane = '0;
    for (int i = 0; i < NumLanes; i++) begin
      if (canGrant[i]) begin
        popData = pushData[i];
        popLane = laneIdxT'(i);
      end
    end
  end

endmodule : flowMuxFixed

/* source/prioMergeTop.sv */
/*
  Priority merge unit, tagged input words into per-lane buffers
  Buffers drain into one stream with lane 0 at the highest priority
  One cycle from input acceptance to first output offer
  Output side is combinational from buffer state
*/
`timescale 1ns/1ps

module prioMergeTop (
  input  logic              clk,
  input  logic              rstN,
  input  logic              inValid,
  output logic              inReady,
  input  mergePkg::dataT    inData,
  input  mergePkg::laneIdxT inLane,
  output logic              outValid,
  input  logic              outReady,
  output mergePkg::dataT    outData,
  output mergePkg::laneIdxT outLane
);

  import mergePkg::*;

  // Steer to buffers
  laneVecT fifoPushValid;
  laneVecT fifoPushReady;

  // Buffers to multiplexer
  laneVecT               fifoPopValid;
  laneVecT               fifoPopReady;
  dataT [NumLanes-1:0]   fifoPopData;

  // ------------------------------------------------------------
  // Input steering
  // ------------------------------------------------------------

  laneSteer uLaneSteer (
    .inValid   (inValid),
    .inReady   (inReady),
    .inLane    (inLane),
    .pushValid (fifoPushValid),
    .fifoReady (fifoPushReady)
  );

  // ------------------------------------------------------------
  // Lane buffers
  // ------------------------------------------------------------

  // Input word fans out to every buffer, only the tagged one pushes
  for (genvar i = 0; i < NumLanes; i++) begin : gLane
    laneFifo uLaneFifo (
      .clk       (clk),
      .rstN      (rstN),
      .pushValid (fifoPushValid[i]),
      .pushReady (fifoPushReady[i]),
      .pushData  (inData),
      .popValid  (fifoPopValid[i]),
      .popReady  (fifoPopReady[i]),
      .popData   (fifoPopData[i])
    );
  end

  // ------------------------------------------------------------
  // Output multiplexer
  // ------------------------------------------------------------

  flowMuxFixed uFlowMuxFixed (
    .pushValid (fifoPopValid),
    .pushReady (fifoPopReady),
    .pushData  (fifoPopData),
    .popValid  (outValid),
    .popReady  (outReady),
    .popData   (outData),
    .popLane   (outLane)
  );

endmodule : prioMergeTop

/* bench/tbClockGen.sv */
/*
  Free-running testbench clock, 20 ns period
  Starts low so the first rising edge falls at 10 ns
*/
`timescale 1ns/1ps

module tbClockGen (
  output logic clk
);

  // Half of the 20 ns period
  localparam time HalfPeriod = 10;

  initial begin
    clk = 1'b0;
    forever begin
      #HalfPeriod clk = ~clk;
    end
  end

endmodule : tbClockGen

/* bench/prioMerge_asserts.sv */
/*
  Handshake rules on the merge unit boundary, bound into prioMergeTop
  All rules are disabled while rstN is low
  laneValid is tapped from the buffer valid vector inside the top level
*/
`timescale 1ns/1ps

module prioMergeAsserts (
  input logic              clk,
  input logic              rstN,
  input logic              inValid,
  input logic              inReady,
  input mergePkg::dataT    inData,
  input mergePkg::laneIdxT inLane,
  input logic              outValid,
  input logic              outReady,
  input mergePkg::laneIdxT outLane,
  input mergePkg::laneVecT laneValid
);

  import mergePkg::*;

  // ------------------------------------------------------------
  // Input side
  // ------------------------------------------------------------

  // Stalled producer keeps its word and tag
  aInHold : assert property (@(posedge clk) disable iff (!rstN)
    inValid && !inReady |=> $stable(inData) && $stable(inLane))
    else $error("input word or tag changed while stalled");

  // ------------------------------------------------------------
  // Output side
  // ------------------------------------------------------------

  // Without a pop the offer cannot go away
  aOutHold : assert property (@(posedge clk) disable iff (!rstN)
    outValid && !outReady |=> outValid)
    else $error("outValid dropped without a pop");

  // Named lane must hold at least one word
  aOutLane : assert property (@(posedge clk) disable iff (!rstN)
    outValid |-> laneValid[outLane])
    else $error("outLane names an empty lane buffer");

endmodule : prioMergeAsserts

bind prioMergeTop prioMergeAsserts uPrioMergeAsserts (
  .clk       (clk),
  .rstN      (rstN),
  .inValid   (inValid),
  .inReady   (inReady),
  .inData    (inData),
  .inLane    (inLane),
  .outValid  (outValid),
  .outReady  (outReady),
  .outLane   (outLane),
  .laneValid (fifoPopValid)
);

/* bench/prioMergeTb.sv */
/*
  Directed tests for the priority merge unit
  Inputs change on the falling edge and handshakes are sampled on the rising edge
  Reference model holds one queue per lane and the lowest non-empty lane drains first
  Run ends on a cycle limit if any test stalls
*/
`timescale 1ns/1ps

module prioMergeTb;

  import mergePkg::*;

  // Generous bound over the summed test lengths
  localparam int TimeoutCycles = 3000;

  logic    clk;
  logic    rstN;
  logic    inValid;
  logic    inReady;
  dataT    inData;
  laneIdxT inLane;
  logic    outValid;
  logic    outReady;
  dataT    outData;
  laneIdxT outLane;

  // Expected words per lane in arrival order
  dataT refQ [NumLanes][$];

  int    seed;
  int    errCount;
  int    checkCount;
  int    outCount;
  int    cycleCount;
  string curTest;

  tbClockGen uTbClockGen (.clk(clk));

  prioMergeTop u_prioMergeTop (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .inReady  (inReady),
    .inData   (inData),
    .inLane   (inLane),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData),
    .outLane  (outLane)
  );

  // ------------------------------------------------------------
  // Check and model helpers
  // ------------------------------------------------------------

  task automatic checkEq(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    checkCount++;
    if (expected !== actual) begin
      errCount++;
      $display("mismatch in %s, %s: expected %0h, actual %0h", curTest, what, expected, actual);
    end
  endtask

  function automatic int refTotal();
    int total;
    total = 0;
    for (int i = 0; i < NumLanes; i++) begin
      total += refQ[i].size();
    end
    return total;
  endfunction

  // Lane that fixed priority should serve next or -1 when all are empty
  function automatic int lowestBusy();
    for (int i = 0; i < NumLanes; i++) begin
      if (refQ[i].size() != 0) begin
        return i;
      end
    end
    return -1;
  endfunction

  // Output is checked before the input push because a new word cannot leave in its own cycle
  always @(posedge clk) begin : refModel
    int lane;
    if (rstN) begin
      if (outValid && outReady) begin
        outCount++;
        lane = lowestBusy();
        if (lane < 0) begin
          errCount++;
          $display("in %s an output word %0h left while no word was outstanding",
                   curTest, outData);
        end else begin
          checkEq("outLane", lane, outLane);
          checkEq("outData", refQ[lane][0], outData);
          void'(refQ[lane].pop_front());
        end
      end
      if (inValid && inReady) begin
        refQ[inLane].push_back(inData);
      end
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TimeoutCycles) begin
      $display("timeout after %0d cycles in %s, the DUT stopped responding", cycleCount, curTest);
      $display("test failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Drive helpers
  // ------------------------------------------------------------

  // Returns after the rising edge that takes the word
  task automatic sendWord(input laneIdxT lane, input dataT data);
    @(negedge clk);
    inValid = 1'b1;
    inLane  = lane;
    inData  = data;
    do begin
      @(posedge clk);
    end while (!inReady);
  endtask

  task automatic stopIn();
    @(negedge clk);
    inValid = 1'b0;
  endtask

  task automatic setOutReady(input logic value);
    @(negedge clk);
    outReady = value;
  endtask

  task automatic waitDrain();
    while (refTotal() != 0) begin
      @(negedge clk);
    end
    #5 checkEq("outValid after drain", 0, outValid);
  endtask

  task automatic reportTest();
    $display("%s finished, %0d errors so far", curTest, errCount);
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------

  task automatic testReset();
    curTest = "reset";
    @(negedge clk);
    #5 checkEq("outValid", 0, outValid);
    // Every tag must find an empty buffer
    for (int t = 0; t < NumLanes; t++) begin
      @(negedge clk);
      inLane = laneIdxT'(t);
      #5 checkEq("inReady", 1, inReady);
    end
    reportTest();
  endtask

  task automatic testLaneOrder();
    int startCount;
    curTest = "laneOrder";
    setOutReady(1'b1);
    startCount = outCount;
    for (int i = 0; i < 8; i++) begin
      sendWord(2'd2, dataT'(16'h2a00 + i));
    end
    stopIn();
    waitDrain();
    checkEq("words out", 8, outCount - startCount);
    reportTest();
  endtask

  task automatic testBackPressure();
    curTest = "backPressure";
    setOutReady(1'b0);
    for (int i = 0; i < FifoDepth; i++) begin
      sendWord(2'd1, dataT'(16'h1b00 + i));
    end
    stopIn();
    #5 checkEq("inReady tag 1 full", 0, inReady);
    @(negedge clk);
    inLane = 2'd3;
    #5 checkEq("inReady tag 3", 1, inReady);
    setOutReady(1'b1);
    waitDrain();
    reportTest();
  endtask

  task automatic testDrainPriority();
    curTest = "drainPriority";
    setOutReady(1'b0);
    sendWord(2'd3, 16'h3c00);
    sendWord(2'd3, 16'h3c01);
    sendWord(2'd0, 16'h0c00);
    sendWord(2'd0, 16'h0c01);
    sendWord(2'd2, 16'h2c00);
    sendWord(2'd2, 16'h2c01);
    stopIn();
    // Model serves lane 0, then 2, then 3
    setOutReady(1'b1);
    waitDrain();
    reportTest();
  endtask

  task automatic testPreempt();
    curTest = "preempt";
    setOutReady(1'b0);
    sendWord(2'd3, 16'h3d05);
    stopIn();
    #5 checkEq("outLane before", 3, outLane);
    checkEq("outData before", 16'h3d05, outData);
    sendWord(2'd1, 16'h1d05);
    stopIn();
    // Higher lane takes over the stalled offer
    #5 checkEq("outLane after", 1, outLane);
    checkEq("outData after", 16'h1d05, outData);
    setOutReady(1'b1);
    waitDrain();
    reportTest();
  endtask

  task automatic testRandomTraffic();
    int   r;
    logic held;
    curTest = "randomTraffic";
    held = 1'b0;
    for (int c = 0; c < 200; c++) begin
      @(negedge clk);
      r = $random(seed);
      // A stalled word stays on the bus until taken
      if (!held) begin
        inValid = r[0];
        inLane  = r[2:1];
        inData  = r[31:16];
      end
      outReady = r[3] | r[4];
      @(posedge clk);
      held = inValid && !inReady;
    end
    stopIn();
    outReady = 1'b1;
    waitDrain();
    reportTest();
  endtask

  // ------------------------------------------------------------
  // Sequence
  // ------------------------------------------------------------

  initial begin
    seed       = 44;
    errCount   = 0;
    checkCount = 0;
    outCount   = 0;
    cycleCount = 0;
    curTest    = "init";
    rstN       = 1'b0;
    inValid    = 1'b0;
    inData     = '0;
    inLane     = '0;
    outReady   = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    testReset();
    testLaneOrder();
    testBackPressure();
    testDrainPriority();
    testPreempt();
    testRandomTraffic();
    $display("checks %0d, errors %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule : prioMergeTb

/* vlog.f */
common/mergePkg.sv
source/laneSteer.sv
source/laneFifo.sv
flowMux/fixedPrioArb.sv
flowMux/flowMuxFixed.sv
source/prioMergeTop.sv
bench/tbClockGen.sv
bench/prioMerge_asserts.sv
bench/prioMergeTb.sv

/* Bender.yml */
package:
  name: prio_merge

sources:
  - files:
      - common/mergePkg.sv
      - source/laneSteer.sv
      - source/laneFifo.sv
      - flowMux/fixedPrioArb.sv
      - flowMux/flowMuxFixed.sv
      - source/prioMergeTop.sv
  - target: simulation
    files:
      - bench/tbClockGen.sv
      - bench/prioMerge_asserts.sv
      - bench/prioMergeTb.sv
